// File: Makefile
# Verilator build and run for the SMC lite testbench

VERILATOR ?= verilator
TOP       ?= smc_lite_tb
FLIST     ?= smc_lite_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the log search
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -qx 'sim passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: smc_access_ctl.sv
/*
 * Access sequencer
 * Splits one transfer into external accesses, two rw cycles each
 */

`timescale 1ns/1ps

module smc_access_ctl
(
   input  logic       sys_clk10,
   input  logic       n_sys_reset10,
   input  logic       valid_access,
   input  logic [1:0] xfer_size,
   input  logic [1:0] bus_size,
   output logic [4:0] smc_nextstate,
   output logic [1:0] r_num_access,
   output logic       smc_done,
   output logic [1:0] v_xfer_size,
   output logic [1:0] v_bus_size
);

   import smc_lite_pkg::*;

   logic [4:0] r_state;      // Current state
   logic       r_phase;      // Second cycle of an access
   logic [1:0] r_xfer_size;  // Stored transfer size
   logic [1:0] r_bus_size;   // Stored bus size
   logic [1:0] num_load;     // Accesses minus one for new transfer

   // ------------------------------
   // Size validation
   // ------------------------------
   // Live sizes in the start cycle, stored ones after
   assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;
   assign v_bus_size  = valid_access ? bus_size  : r_bus_size;

   // Transfer bytes over bus bytes, at least one
   always_comb
   begin
      case ({xfer_size, bus_size})
         {xsiz_32, bsiz_8}  : num_load = 2'd3;
         {xsiz_32, bsiz_16} : num_load = 2'd1;
         {xsiz_16, bsiz_8}  : num_load = 2'd1;
         default            : num_load = 2'd0;   // Bus as wide as transfer or wider
      endcase
   end

   // ------------------------------
   // Next state
   // ------------------------------
   always_comb
   begin
      case (r_state)
         smc_idle    : smc_nextstate = valid_access ? smc_rw : smc_idle;
         smc_rw      : smc_nextstate = (r_phase && (r_num_access == 2'd0)) ?
                                       smc_done_st : smc_rw;
         smc_done_st : smc_nextstate = smc_idle;
         default     : smc_nextstate = smc_idle;     // Illegal code recovers
      endcase
   end

   // Last access ends
   assign smc_done = (r_state == smc_rw) && r_phase && (r_num_access == 2'd0);

   // ------------------------------
   // State, phase and counter
   // ------------------------------
   always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
   begin
      if (!n_sys_reset10)
      begin
         r_state      <= smc_idle;
         r_phase      <= 1'b0;
         r_num_access <= 2'd0;
         r_xfer_size  <= xsiz_8;
         r_bus_size   <= bsiz_8;
      end
      else
      begin
         r_state <= smc_nextstate;
         r_phase <= (r_state == smc_rw) && !r_phase;   // Toggles while in rw
         if (valid_access)
         begin
            r_num_access <= num_load;
            r_xfer_size  <= xfer_size;
            r_bus_size   <= bus_size;
         end
         else if ((r_state == smc_rw) && r_phase && (r_num_access != 2'd0))
            r_num_access <= r_num_access - 2'd1;       // One access finished
      end
   end

endmodule

// File: smc_addr_lite.sv
/*
 * Address stage
 * Registers the external address, chip select and byte enables per access
 */

`timescale 1ns/1ps

module smc_addr_lite
(
   input  logic        sys_clk10,
   input  logic        n_sys_reset10,
   input  logic        valid_access,
   input  logic [1:0]  r_num_access,
   input  logic [1:0]  v_bus_size,
   input  logic [1:0]  v_xfer_size,
   input  logic        cs,
   input  logic [31:0] addr,
   input  logic        smc_done,
   input  logic [4:0]  smc_nextstate,
   output logic [31:0] smc_addr,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_cs,
   output logic [3:0]  n_be
);

   import smc_lite_pkg::*;

   logic       r_cs;      // Stored chip select
   logic [1:0] r_addr;    // Stored low address bits
   logic       v_cs;      // Validated chip select
   logic [1:0] v_addr;    // Validated low address bits
   logic       r_rw;      // Sequencer sits in rw
   logic       r_second;  // Second rw cycle of an access
   logic       acc_next;  // Access ends, another follows

   // ------------------------------
   // Stored request and rw tracking
   // ------------------------------
   always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
   begin
      if (!n_sys_reset10)
      begin
         r_cs     <= 1'b0;
         r_rw     <= 1'b0;
         r_second <= 1'b0;
      end
      else
      begin
         if (valid_access)
            r_cs <= cs;
         r_rw     <= (smc_nextstate == smc_rw);
         r_second <= r_rw && !r_second;
      end
   end

   always_ff @(posedge sys_clk10)
   begin
      if (valid_access)
         r_addr <= addr[1:0];
   end

   assign v_cs   = valid_access ? cs        : r_cs;
   assign v_addr = valid_access ? addr[1:0] : r_addr;

   assign acc_next = r_rw && r_second && !smc_done;   // Final end is smc_done

   // ------------------------------
   // External address
   // ------------------------------
   // Little-endian, highest byte offset first
   always_ff @(posedge sys_clk10)
   begin
      if (valid_access)
      begin
         smc_addr[31:2] <= addr[31:2];
         case ({v_xfer_size, v_bus_size})
            {xsiz_32, bsiz_32} : smc_addr[1:0] <= 2'b00;
            {xsiz_32, bsiz_16} : smc_addr[1:0] <= 2'b10;
            {xsiz_32, bsiz_8}  : smc_addr[1:0] <= 2'b11;
            {xsiz_16, bsiz_8}  : smc_addr[1:0] <= {addr[1], 1'b1};
            {xsiz_16, bsiz_16},
            {xsiz_16, bsiz_32} : smc_addr[1:0] <= {addr[1], 1'b0};   // Halfword aligned
            default            : smc_addr[1:0] <= addr[1:0];         // Bytes as given
         endcase
      end
      else if (acc_next)
      begin
         case ({v_xfer_size, v_bus_size})
            {xsiz_32, bsiz_16} : smc_addr[1:0] <= 2'b00;
            {xsiz_32, bsiz_8}  : smc_addr[1:0] <= r_num_access - 2'd1;   // 3, 2, 1, 0
            {xsiz_16, bsiz_8}  : smc_addr[1:0] <= {r_addr[1], 1'b0};
            default            : smc_addr[1:0] <= smc_addr[1:0];         // Single access
         endcase
      end
   end

   // ------------------------------
   // Internal byte enables
   // ------------------------------
   always_comb
   begin
      n_be = 4'b1111;
      if (v_cs)
      begin
         case ({v_xfer_size, v_bus_size})
            {xsiz_8, bsiz_8}   : n_be = 4'b1110;                          // Lane 0
            {xsiz_8, bsiz_16}  : n_be = v_addr[0] ? 4'b1101 : 4'b1110;
            {xsiz_8, bsiz_32}  : n_be = ~(4'b0001 << v_addr);            // One lane of four
            {xsiz_16, bsiz_8}  : n_be = 4'b1110;
            {xsiz_16, bsiz_16} : n_be = 4'b1100;
            {xsiz_16, bsiz_32} : n_be = v_addr[1] ? 4'b0011 : 4'b1100;
            {xsiz_32, bsiz_8}  : n_be = 4'b1110;
            {xsiz_32, bsiz_16} : n_be = 4'b1100;
            {xsiz_32, bsiz_32} : n_be = 4'b0000;                          // Full word
            default            : n_be = 4'b1111;                          // Bad decode
         endcase
      end
   end

   // ------------------------------
   // Registered chip select and enables
   // ------------------------------
   always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
   begin
      if (!n_sys_reset10)
      begin
         smc_n_cs <= 1'b1;
         smc_n_be <= 4'hf;
      end
      else if (smc_nextstate == smc_rw)
      begin
         smc_n_cs <= !v_cs;
         smc_n_be <= n_be;
      end
      else
      begin
         smc_n_cs <= 1'b1;   // Bus idle outside rw
         smc_n_be <= 4'hf;
      end
   end

endmodule

// File: smc_apb_front.sv
/*
 * APB slave front stage
 * Captures one transfer, decodes the SRAM window and returns the response
 */

`timescale 1ns/1ps

module smc_apb_front
(
   input  logic        sys_clk10,
   input  logic        n_sys_reset10,
   // APB slave
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic [1:0]  psize,
   output logic        pready,
   output logic [31:0] prdata,
   output logic        pslverr,
   // To the controller
   output logic        valid_access,
   output logic        cs,
   output logic [31:0] addr,
   output logic [1:0]  xfer_size,
   output logic        write,
   output logic [31:0] wdata,
   input  logic        smc_done,
   input  logic [31:0] rd_word
);

   import smc_lite_pkg::*;

   logic r_busy;     // Transfer accepted, waiting for response
   logic r_ready;    // Registered pready for in-window transfers
   logic err_access; // Out-of-window access phase

   // ------------------------------
   // Request capture in setup phase
   // ------------------------------
   always_ff @(posedge sys_clk10)
   begin
      if (psel && !penable)
      begin
         addr      <= paddr;
         wdata     <= pwdata;
         write     <= pwrite;
         xfer_size <= (psize == 2'b11) ? xsiz_32 : psize;   // Reserved code as word
      end
   end

   // Window decode, control state
   always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
   begin
      if (!n_sys_reset10)
      begin
         cs      <= 1'b0;
         r_busy  <= 1'b0;
         r_ready <= 1'b0;
      end
      else
      begin
         if (psel && !penable)
            cs <= (paddr[smc_win_msb:smc_win_lsb] == smc_bank_base);
         if (valid_access)
            r_busy <= 1'b1;
         else if (r_ready)
            r_busy <= 1'b0;                      // Master leaves access phase now
         r_ready <= smc_done;                    // One cycle after last access
      end
   end

   // Read word held for the response cycle
   always_ff @(posedge sys_clk10)
   begin
      if (smc_done)
         prdata <= rd_word;
   end

   // One pulse per transfer, first access-phase cycle
   assign valid_access = psel && penable && cs && !r_busy;
   assign err_access   = psel && penable && !cs;    // No external access

   assign pready  = r_ready || err_access;
   assign pslverr = err_access;

endmodule

// File: smc_data_lane.sv
/*
 * Data lane stage
 * Steers write bytes onto the SRAM lanes, drives the strobe, gathers reads
 */

`timescale 1ns/1ps

module smc_data_lane
(
   input  logic        sys_clk10,
   input  logic        n_sys_reset10,
   input  logic [4:0]  smc_nextstate,
   input  logic        write,
   input  logic [31:0] wdata,
   input  logic [31:0] smc_addr,
   input  logic [3:0]  n_be,
   input  logic [1:0]  v_bus_size,
   input  logic [31:0] smc_data_in,
   output logic [31:0] smc_data_out,
   output logic        smc_n_we,
   output logic [31:0] rd_word
);

   import smc_lite_pkg::*;

   logic        r_rw;      // Sequencer sits in rw
   logic        r_second;  // Second rw cycle of an access
   logic [31:0] r_rd;      // Bytes gathered so far
   logic [31:0] rd_merge;  // Gathered bytes plus current lanes

   // Word byte carried on a bus lane, lane = byte mod bus bytes
   function automatic logic [1:0] byte_pos(input logic [1:0] bsz, input logic [1:0] a,
                                           input logic [1:0] lane);
      case (bsz)
         bsiz_8  : byte_pos = a;                // Only lane 0 used
         bsiz_16 : byte_pos = {a[1], lane[0]};
         default : byte_pos = lane;
      endcase
   endfunction

   // ------------------------------
   // Access phase and write strobe
   // ------------------------------
   always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
   begin
      if (!n_sys_reset10)
      begin
         r_rw     <= 1'b0;
         r_second <= 1'b0;
         smc_n_we <= 1'b1;
      end
      else
      begin
         r_rw     <= (smc_nextstate == smc_rw);
         r_second <= r_rw && !r_second;
         smc_n_we <= !(write && r_rw && !r_second);   // Low in second cycle only
      end
   end

   // ------------------------------
   // Lane steering
   // ------------------------------
   always_comb
   begin
      smc_data_out = 32'h0;
      rd_merge     = r_rd;
      for (int l = 0; l < 4; l++)
      begin
         if (!n_be[l])
         begin
            smc_data_out[8*l +: 8] = wdata[8*byte_pos(v_bus_size, smc_addr[1:0], 2'(l)) +: 8];
            if (r_second && !write)
               rd_merge[8*byte_pos(v_bus_size, smc_addr[1:0], 2'(l)) +: 8] =
                  smc_data_in[8*l +: 8];   // Sampled at end of access
         end
      end
   end

   // Gathered read bytes
   always_ff @(posedge sys_clk10)
   begin
      r_rd <= rd_merge;
   end

   assign rd_word = rd_merge;   // Complete while smc_done is high

endmodule

// File: smc_lite_clk_gen.sv
/*
 * Testbench clock and reset
 * 4 ns sys_clk10, reset held low for 5 cycles
 */

`timescale 1ns/1ps

module smc_lite_clk_gen
(
   output logic sys_clk10,
   output logic n_sys_reset10
);

   initial
   begin
      sys_clk10 = 1'b0;
      forever #2 sys_clk10 = ~sys_clk10;   // 250 MHz
   end

   initial
   begin
      n_sys_reset10 = 1'b0;
      repeat (5) @(posedge sys_clk10);
      @(negedge sys_clk10);                // Release away from the active edge
      n_sys_reset10 = 1'b1;
   end

endmodule

// File: smc_lite_pkg.sv
/*
 * SMC lite shared definitions
 * Size codes, sequencer state codes and the SRAM address window
 */

package smc_lite_pkg;

   // ------------------------------
   // Transfer size codes (APB psize)
   // ------------------------------
   localparam logic [1:0] xsiz_8  = 2'b00;   // Byte
   localparam logic [1:0] xsiz_16 = 2'b01;   // Halfword
   localparam logic [1:0] xsiz_32 = 2'b10;   // Word

   // ------------------------------
   // External bus size codes (strap)
   // ------------------------------
   localparam logic [1:0] bsiz_8  = 2'b00;   // 8-bit SRAM
   localparam logic [1:0] bsiz_16 = 2'b01;   // 16-bit SRAM
   localparam logic [1:0] bsiz_32 = 2'b10;   // 32-bit SRAM

   // ------------------------------
   // Sequencer states, one-hot
   // ------------------------------
   localparam logic [4:0] smc_idle    = 5'b00001;   // Waiting for a transfer
   localparam logic [4:0] smc_rw      = 5'b00010;   // CS and BE active
   localparam logic [4:0] smc_done_st = 5'b00100;   // Response cycle

   // ------------------------------
   // SRAM address window
   // ------------------------------
   // Top nibble of paddr selects the bank
   localparam int unsigned smc_win_msb   = 31;
   localparam int unsigned smc_win_lsb   = 28;
   localparam logic [3:0]  smc_bank_base = 4'h6;   // 0x6000_0000 .. 0x6FFF_FFFF

endpackage

// File: smc_lite_props.sv
/*
 * SRAM bus and APB protocol properties
 * Bound to the SMC lite top level
 */

`timescale 1ns/1ps

module smc_lite_props
(
   input logic       sys_clk10,
   input logic       n_sys_reset10,
   input logic       psel,
   input logic       penable,
   input logic       pready,
   input logic       smc_n_cs,
   input logic       smc_n_we,
   input logic [3:0] smc_n_be
);

   // Enables only inside a chip select
   be_idle_a: assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
      smc_n_cs |-> (smc_n_be == 4'hf))
      else $error("byte enables active with chip select high");

   // Strobe never outside an access
   we_in_cs_a: assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
      !smc_n_we |-> !smc_n_cs)
      else $error("write strobe low with chip select high");

   ready_phase_a: assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
      pready |-> (psel && penable))   // Response only in access phase
      else $error("pready outside an APB access phase");

endmodule

// File: smc_lite_tb.sv
/*
 * SMC lite testbench
 * Table driven APB transfers against a byte-array SRAM model
 */

`timescale 1ns/1ps

module smc_lite_tb;

   import smc_lite_pkg::*;

   localparam int n_rows     = 20;
   localparam int max_cycles = n_rows * 12 + 50;   // Longest row is 12 cycles

   logic        sys_clk10;
   logic        n_sys_reset10;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] paddr;
   logic [31:0] pwdata;
   logic [1:0]  psize;
   logic        pready;
   logic [31:0] prdata;
   logic        pslverr;
   logic [1:0]  bus_size;
   logic [31:0] smc_data_in;
   logic [31:0] smc_addr;
   logic [3:0]  smc_n_be;
   logic        smc_n_cs;
   logic        smc_n_we;
   logic [31:0] smc_data_out;

   // ------------------------------
   // Stimulus table, one row per transfer
   // ------------------------------
   logic        tbl_write [n_rows];
   logic [31:0] tbl_addr  [n_rows];
   logic [1:0]  tbl_size  [n_rows];
   logic [1:0]  tbl_bus   [n_rows];
   logic [31:0] tbl_data  [n_rows];   // Write data, or expected read data
   logic        tbl_err   [n_rows];

   logic [7:0]  sram [256];           // Low address byte selects
   logic [1:0]  obs_off [$];          // Seen per access
   logic [29:0] obs_hi [$];           // Word address bits seen per access
   logic [3:0]  obs_nbe [$];
   logic [1:0]  exp_off [$];          // Derived per access
   logic [3:0]  exp_nbe [$];
   logic        cs_second;
   int          errors;
   int          checks;
   int          cycles = 0;

   smc_lite_clk_gen clk_gen_i (.sys_clk10, .n_sys_reset10);

   smc_lite_top dut_i
   (
      .sys_clk10, .n_sys_reset10, .psel, .penable, .pwrite, .paddr, .pwdata, .psize,
      .pready, .prdata, .pslverr, .bus_size, .smc_data_in, .smc_addr, .smc_n_be,
      .smc_n_cs, .smc_n_we, .smc_data_out
   );

   bind smc_lite_top smc_lite_props props_i
   (
      .sys_clk10 (sys_clk10), .n_sys_reset10 (n_sys_reset10), .psel (psel),
      .penable (penable), .pready (pready), .smc_n_cs (smc_n_cs), .smc_n_we (smc_n_we),
      .smc_n_be (smc_n_be)
   );

   function automatic int xfer_bytes(input logic [1:0] code);
      if (code == xsiz_8) return 1;
      else if (code == xsiz_16) return 2;
      else return 4;
   endfunction

   function automatic int bus_bytes(input logic [1:0] code);
      if (code == bsiz_8) return 1;
      else if (code == bsiz_16) return 2;
      else return 4;
   endfunction

   // Memory byte on a lane, bus-aligned base plus lane
   function automatic logic [7:0] lane_byte_addr(input logic [31:0] a, input logic [1:0] bus,
                                                 input int lane);
      if (bus == bsiz_8) return a[7:0];
      else if (bus == bsiz_16) return {a[7:1], 1'b0} + 8'(lane);
      else return {a[7:2], 2'b00} + 8'(lane);
   endfunction

   // Bytes of the transfer within the 32-bit word
   function automatic logic [31:0] size_mask(input logic [1:0] sz, input logic [31:0] a);
      int          t;
      int          base;
      logic [31:0] m;
      t    = xfer_bytes(sz);
      base = int'(a[1:0]) - (int'(a[1:0]) % t);
      m    = '0;
      for (int k = 0; k < 4; k++)
         if (k >= base && k < base + t)
            m[8*k +: 8] = 8'hff;
      return m;
   endfunction

   // ------------------------------
   // Expected access list
   // ------------------------------
   // N = max(1, T/B), highest chunk first, min(T, B) lanes each
   task automatic build_expected(input logic [1:0] sz, input logic [1:0] bus,
                                 input logic [31:0] a);
      int         t;
      int         b;
      int         n;
      int         w;
      int         base;
      int         off;
      logic [3:0] lanes;
      exp_off.delete();
      exp_nbe.delete();
      t    = xfer_bytes(sz);
      b    = bus_bytes(bus);
      n    = (t / b < 1) ? 1 : t / b;
      w    = (t < b) ? t : b;
      base = int'(a[1:0]) - (int'(a[1:0]) % t);
      for (int i = n - 1; i >= 0; i--)
      begin
         off   = base + i * b;
         lanes = 4'((1 << w) - 1) << (off % b);
         exp_off.push_back(2'(off));
         exp_nbe.push_back(~lanes);
      end
   endtask

   task automatic fill_table();
      int          row;
      logic [1:0]  sz;
      logic [1:0]  bus;
      logic [31:0] a;
      logic [31:0] d;
      row = 0;
      for (int b = 0; b < 3; b++)
      begin
         for (int s = 0; s < 3; s++)
         begin
            sz  = (s == 0) ? xsiz_8 : (s == 1) ? xsiz_16 : xsiz_32;
            bus = (b == 0) ? bsiz_8 : (b == 1) ? bsiz_16 : bsiz_32;
            a   = 32'h6000_0000 + 32'(16 * (3 * b + s));   // Own slot per combination
            if (sz == xsiz_8)
               a[1:0] = 2'(b + 1);                         // Odd and even byte lanes
            else if (sz == xsiz_16)
               a[1:0] = (b == 1) ? 2'b10 : 2'b00;
            d = $urandom;
            for (int k = 0; k < 2; k++)
            begin
               tbl_write[row + k] = (k == 0);              // Write, then read back
               tbl_addr[row + k]  = a;
               tbl_size[row + k]  = sz;
               tbl_bus[row + k]   = bus;
               tbl_data[row + k]  = d;
               tbl_err[row + k]   = 1'b0;
            end
            row += 2;
         end
      end
      // Out-of-window pair
      tbl_write[18] = 1'b1;
      tbl_addr[18]  = 32'h7000_0040;
      tbl_size[18]  = xsiz_32;
      tbl_bus[18]   = bsiz_8;
      tbl_data[18]  = $urandom;
      tbl_err[18]   = 1'b1;
      tbl_write[19] = 1'b0;
      tbl_addr[19]  = 32'h1000_0008;
      tbl_size[19]  = xsiz_16;
      tbl_bus[19]   = bsiz_16;
      tbl_data[19]  = 32'h0;
      tbl_err[19]   = 1'b1;
   endtask

   // APB master, drives on the falling edge
   task automatic apb_transfer(input int r, output logic [31:0] rdata, output logic err,
                               output int latency);
      int   waits;
      logic got;
      @(negedge sys_clk10);
      obs_off.delete();                 // Bus idle here
      obs_hi.delete();
      obs_nbe.delete();
      bus_size = tbl_bus[r];
      psel     = 1'b1;
      penable  = 1'b0;
      pwrite   = tbl_write[r];
      paddr    = tbl_addr[r];
      pwdata   = tbl_write[r] ? tbl_data[r] : 32'h0;
      psize    = tbl_size[r];
      @(negedge sys_clk10);
      penable = 1'b1;
      waits   = 0;
      got     = 1'b0;
      while (!got)
      begin
         @(posedge sys_clk10);          // Values settled since the falling edge
         waits++;
         if (pready)
         begin
            got   = 1'b1;
            rdata = prdata;
            err   = pslverr;
         end
      end
      latency = waits - 1;              // Cycles after first access-phase cycle
      @(negedge sys_clk10);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // ------------------------------
   // SRAM model and bus monitor
   // ------------------------------
   always_comb
   begin
      smc_data_in = '0;
      for (int l = 0; l < 4; l++)
         if (l < bus_bytes(bus_size))
            smc_data_in[8*l +: 8] = sram[lane_byte_addr(smc_addr, bus_size, l)];
   end

   always @(negedge sys_clk10)
   begin
      if (!n_sys_reset10)
      begin
         for (int i = 0; i < 256; i++)
            sram[i] = 8'(i * 37) ^ 8'h5a;             // Pattern over the full index
      end
      else if (!smc_n_cs && !smc_n_we)
      begin
         for (int l = 0; l < 4; l++)
            if (!smc_n_be[l] && l < bus_bytes(bus_size))
               sram[lane_byte_addr(smc_addr, bus_size, l)] = smc_data_out[8*l +: 8];
      end
   end

   // One entry per access, on its first cs cycle
   always @(negedge sys_clk10)
   begin
      if (!n_sys_reset10 || smc_n_cs)
         cs_second <= 1'b0;
      else
      begin
         if (!cs_second)
         begin
            obs_off.push_back(smc_addr[1:0]);
            obs_hi.push_back(smc_addr[31:2]);
            obs_nbe.push_back(smc_n_be);
         end
         cs_second <= !cs_second;
      end
   end

   // Run limit
   always @(posedge sys_clk10)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout after %0d cycles, a transfer never completed", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin
      logic [31:0] rd;
      logic        err;
      int          lat;
      int          exp_lat;
      logic [31:0] mask;
      void'($urandom(34979));
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = 32'h0;
      pwdata   = 32'h0;
      psize    = xsiz_8;
      bus_size = bsiz_32;
      errors   = 0;
      checks   = 0;
      fill_table();

      repeat (2) @(negedge sys_clk10);   // Still in reset
      checks++;
      if (pready !== 1'b0 || smc_n_cs !== 1'b1 || smc_n_be !== 4'hf || smc_n_we !== 1'b1)
      begin
         $display("FAILED %0t: reset values pready %b n_cs %b n_be %b n_we %b", $time,
                  pready, smc_n_cs, smc_n_be, smc_n_we);
         errors++;
      end
      wait (n_sys_reset10 === 1'b1);

      for (int r = 0; r < n_rows; r++)
      begin
         apb_transfer(r, rd, err, lat);
         checks++;
         if (err !== tbl_err[r])
         begin
            $display("FAILED %0t: row %0d pslverr %b expected %b", $time, r, err, tbl_err[r]);
            errors++;
         end
         if (tbl_err[r])
         begin
            exp_off.delete();            // No external access at all
            exp_nbe.delete();
         end
         else
            build_expected(tbl_size[r], tbl_bus[r], tbl_addr[r]);
         checks++;
         if (obs_off.size() != exp_off.size())
         begin
            $display("FAILED %0t: row %0d saw %0d accesses, expected %0d", $time, r,
                     obs_off.size(), exp_off.size());
            errors++;
         end
         else
         begin
            for (int k = 0; k < exp_off.size(); k++)
               if (obs_hi[k] !== tbl_addr[r][31:2] || obs_off[k] !== exp_off[k] ||
                   obs_nbe[k] !== exp_nbe[k])
               begin
                  $display("FAILED %0t: row %0d access %0d addr %h n_be %b, expected %h %b",
                           $time, r, k, {obs_hi[k], obs_off[k]}, obs_nbe[k],
                           {tbl_addr[r][31:2], exp_off[k]}, exp_nbe[k]);
                  errors++;
               end
         end
         // Error response in the first access-phase cycle
         exp_lat = tbl_err[r] ? 0 : 2 * exp_off.size() + 1;
         checks++;
         if (lat != exp_lat)
         begin
            $display("FAILED %0t: row %0d pready after %0d cycles, expected %0d", $time, r,
                     lat, exp_lat);
            errors++;
         end
         if (!tbl_write[r] && !tbl_err[r])
         begin
            mask = size_mask(tbl_size[r], tbl_addr[r]);
            checks++;
            if ((rd & mask) !== (tbl_data[r] & mask))
            begin
               $display("FAILED %0t: row %0d prdata %h expected %h under mask %h", $time, r,
                        rd, tbl_data[r], mask);
               errors++;
            end
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// File: smc_lite_top.f
smc_lite_pkg.sv
smc_apb_front.sv
smc_access_ctl.sv
smc_addr_lite.sv
smc_data_lane.sv
smc_lite_top.sv
smc_lite_props.sv
smc_lite_clk_gen.sv
smc_lite_tb.sv

// File: smc_lite_top.sv
/*
 * SMC lite top level
 * APB front, access sequencer, address stage and data lane stage
 */

`timescale 1ns/1ps

module smc_lite_top
(
   input  logic        sys_clk10,
   input  logic        n_sys_reset10,
   // APB slave
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [31:0] paddr,
   input  logic [31:0] pwdata,
   input  logic [1:0]  psize,
   output logic        pready,
   output logic [31:0] prdata,
   output logic        pslverr,
   // SRAM bus
   input  logic [1:0]  bus_size,
   input  logic [31:0] smc_data_in,
   output logic [31:0] smc_addr,
   output logic [3:0]  smc_n_be,
   output logic        smc_n_cs,
   output logic        smc_n_we,
   output logic [31:0] smc_data_out
);

   // ------------------------------
   // Stage interconnect
   // ------------------------------
   logic        valid_access;
   logic        cs;
   logic [31:0] addr;
   logic [1:0]  xfer_size;
   logic        write;
   logic [31:0] wdata;
   logic        smc_done;
   logic [31:0] rd_word;
   logic [4:0]  smc_nextstate;
   logic [1:0]  r_num_access;
   logic [1:0]  v_xfer_size;
   logic [1:0]  v_bus_size;
   logic [3:0]  n_be;         // Unregistered enables for lane steering

   smc_apb_front front_i
   (
      .sys_clk10     (sys_clk10),
      .n_sys_reset10 (n_sys_reset10),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .paddr         (paddr),
      .pwdata        (pwdata),
      .psize         (psize),
      .pready        (pready),
      .prdata        (prdata),
      .pslverr       (pslverr),
      .valid_access  (valid_access),
      .cs            (cs),
      .addr          (addr),
      .xfer_size     (xfer_size),
      .write         (write),
      .wdata         (wdata),
      .smc_done      (smc_done),
      .rd_word       (rd_word)
   );

   smc_access_ctl access_ctl_i
   (
      .sys_clk10     (sys_clk10),
      .n_sys_reset10 (n_sys_reset10),
      .valid_access  (valid_access),
      .xfer_size     (xfer_size),
      .bus_size      (bus_size),
      .smc_nextstate (smc_nextstate),
      .r_num_access  (r_num_access),
      .smc_done      (smc_done),
      .v_xfer_size   (v_xfer_size),
      .v_bus_size    (v_bus_size)
   );

   smc_addr_lite addr_lite_i
   (
      .sys_clk10     (sys_clk10),
      .n_sys_reset10 (n_sys_reset10),
      .valid_access  (valid_access),
      .r_num_access  (r_num_access),
      .v_bus_size    (v_bus_size),
      .v_xfer_size   (v_xfer_size),
      .cs            (cs),
      .addr          (addr),
      .smc_done      (smc_done),
      .smc_nextstate (smc_nextstate),
      .smc_addr      (smc_addr),
      .smc_n_be      (smc_n_be),
      .smc_n_cs      (smc_n_cs),
      .n_be          (n_be)
   );

   smc_data_lane data_lane_i
   (
      .sys_clk10     (sys_clk10),
      .n_sys_reset10 (n_sys_reset10),
      .smc_nextstate (smc_nextstate),
      .write         (write),
      .wdata         (wdata),
      .smc_addr      (smc_addr),
      .n_be          (n_be),
      .v_bus_size    (v_bus_size),
      .smc_data_in   (smc_data_in),
      .smc_data_out  (smc_data_out),
      .smc_n_we      (smc_n_we),
      .rd_word       (rd_word)
   );

endmodule
